//--- include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Register and ALU word
`define CORE_DATA_W 32

// One RAM word holds one instruction
`define CORE_INSTR_W 16

`define CORE_ADDR_W 12

// Stack lives in the top page of the address space
`define CORE_SP_W 10

`define CORE_REG_AW 3

// First fetch after reset
`define CORE_RESET_IP 8

`define CORE_COND_REG 5  // Register tested by the jumps

`endif

//--- logic/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    typedef enum logic [3:0] {
        OP_SYS   = 4'd0,
        OP_ARITH = 4'd1,
        OP_LOGIC = 4'd2,
        OP_STORE = 4'd3,
        OP_MOVLL = 4'd4,
        OP_MOVLH = 4'd5,
        OP_MOVHL = 4'd6,
        OP_MOVHH = 4'd7,
        OP_ADDB  = 4'd8,
        OP_SUBB  = 4'd9,
        OP_MULB  = 4'd10
    } op_e;

    // Function field of OP_SYS in bits 4..0
    typedef enum logic [4:0] {
        F_END    = 5'd0,
        F_RET    = 5'd1,
        F_NOP    = 5'd3,
        F_OUT    = 5'd12,
        F_PUSHL  = 5'd13,
        F_PUSHH  = 5'd14,
        F_MOV    = 5'd16,
        F_NOT    = 5'd17,
        F_NEG    = 5'd18,
        F_LDRAML = 5'd24,
        F_LDRAMH = 5'd25,
        F_POPL   = 5'd26,
        F_POPH   = 5'd27,
        F_MOVL   = 5'd29,
        F_MOVH   = 5'd30,
        F_MOVD   = 5'd31
    } func_e;

    typedef enum logic [2:0] {
        C_CALL, C_JMP, C_JEZ, C_JNZ, C_JAZ, C_JBZ, C_JAEZ, C_JBEZ
    } cond_e;

    typedef enum logic [3:0] {
        ALU_PASS, ALU_NOT, ALU_NEG, ALU_ADD, ALU_SUB, ALU_MUL, ALU_AND, ALU_OR, ALU_XOR
    } alu_op_e;

    typedef union packed {
        struct packed {
            logic                    kind;
            op_e                     op;
            logic [`CORE_REG_AW-1:0] rd;
            logic [`CORE_REG_AW-1:0] ra;
            logic [`CORE_REG_AW-1:0] rb;
            logic [1:0]              sub;
        } reg_f;
        struct packed {
            logic                    kind;
            op_e                     op;
            logic [`CORE_REG_AW-1:0] rd;
            logic [7:0]              imm;
        } imm_f;
        struct packed {
            logic                    kind;  // Set for the jump family
            cond_e                   cond;
            logic [`CORE_ADDR_W-1:0] addr;
        } jmp_f;
    } instr_u;

endpackage

//--- logic/core_regfile.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_regfile (
    input  logic                    CLK,
    input  logic                    arst_n,
    input  logic [`CORE_REG_AW-1:0] rd_idx0,
    input  logic [`CORE_REG_AW-1:0] rd_idx1,
    input  logic [`CORE_REG_AW-1:0] wr_idx,
    input  logic                    wr_en_h,
    input  logic                    wr_en_l,
    input  logic [`CORE_DATA_W-1:0] wr_data,
    output logic [`CORE_DATA_W-1:0] rd_data0,
    output logic [`CORE_DATA_W-1:0] rd_data1
);
    localparam int NREGS = 1 << `CORE_REG_AW;
    localparam int HALF  = `CORE_DATA_W / 2;

    logic [`CORE_DATA_W-1:0] regs [NREGS];

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_en_h) begin
                regs[wr_idx][`CORE_DATA_W-1:HALF] <= wr_data[`CORE_DATA_W-1:HALF];
            end
            if (wr_en_l) begin
                regs[wr_idx][HALF-1:0] <= wr_data[HALF-1:0];
            end
        end
    end

    assign rd_data0 = regs[rd_idx0];
    assign rd_data1 = regs[rd_idx1];

endmodule

//--- logic/core_alu.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_alu (
    input  core_pkg::alu_op_e       alu_op,
    input  logic [`CORE_DATA_W-1:0] arg0,
    input  logic [`CORE_DATA_W-1:0] arg1,
    output logic [`CORE_DATA_W-1:0] ans
);
    import core_pkg::*;

    always_comb begin
        case (alu_op)
            ALU_PASS: begin
                ans = arg0;
            end
            ALU_NOT: begin
                ans = ~arg0;
            end
            ALU_NEG: begin
                ans = -arg0;
            end
            ALU_ADD: begin
                ans = arg0 + arg1;
            end
            ALU_SUB: begin
                ans = arg0 - arg1;
            end
            ALU_MUL: begin
                ans = arg0 * arg1;  // Low word only
            end
            ALU_AND: begin
                ans = arg0 & arg1;
            end
            ALU_OR: begin
                ans = arg0 | arg1;
            end
            ALU_XOR: begin
                ans = arg0 ^ arg1;
            end
            default: begin
                ans = arg0;
            end
        endcase
    end

endmodule

//--- logic/core_control.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_control (
    input  logic                     CLK,
    input  logic                     arst_n,
    input  logic [`CORE_INSTR_W-1:0] ram_q,
    input  logic [`CORE_DATA_W-1:0]  rd_data0,
    input  logic [`CORE_DATA_W-1:0]  rd_data1,
    input  logic [`CORE_DATA_W-1:0]  alu_ans,
    output logic [`CORE_REG_AW-1:0]  rd_idx0,
    output logic [`CORE_REG_AW-1:0]  rd_idx1,
    output logic [`CORE_REG_AW-1:0]  wr_idx,
    output logic                     wr_en_h,
    output logic                     wr_en_l,
    output logic [`CORE_DATA_W-1:0]  wr_data,
    output core_pkg::alu_op_e        alu_op,
    output logic [`CORE_DATA_W-1:0]  alu_arg1,
    output logic [`CORE_ADDR_W-1:0]  ram_addr,
    output logic                     ram_wren,
    output logic [`CORE_INSTR_W-1:0] ram_data,
    output logic                     [`CORE_DATA_W-1:0] out_data,
    output logic                     running
);
    import core_pkg::*;

    localparam int HALF   = `CORE_DATA_W / 2;
    localparam int PAGE_W = `CORE_ADDR_W - `CORE_SP_W;

    typedef enum logic [2:0] {
        S_ISSUE, S_WAIT, S_EXEC, S_MADDR, S_MHIGH, S_MDATA, S_STORE, S_HALT
    } state_e;

    state_e                  state;
    instr_u                  ir;
    logic [`CORE_ADDR_W-1:0] ip;
    logic [`CORE_SP_W-1:0]   sp;
    logic [`CORE_REG_AW-1:0] pend_idx;
    logic                    pend_h;
    logic                    pend_l;

    op_e                     op;
    func_e                   func;
    cond_e                   cond;
    logic                    is_jump;
    logic                    is_sys;
    logic                    is_imm;
    logic                    is_movd;
    logic                    is_ret;
    logic                    exec_wr;
    logic                    write_high;
    logic                    taken;
    logic [`CORE_DATA_W-1:0] ex_data;
    logic [`CORE_ADDR_W-1:0] ip_inc;
    logic [`CORE_ADDR_W-1:0] ip_inc2;
    logic [`CORE_ADDR_W-1:0] jmp_target;
    logic [`CORE_SP_W-1:0]   sp_inc;
    logic [`CORE_SP_W-1:0]   sp_dec;

    assign op      = ir.reg_f.op;
    assign func    = func_e'({ir.reg_f.rb, ir.reg_f.sub});
    assign cond    = ir.jmp_f.cond;
    assign is_jump = ir.jmp_f.kind;
    assign is_sys  = !is_jump && (op == OP_SYS);
    assign is_imm  = !is_jump && (op inside {[OP_MOVLL:OP_MULB]});
    assign is_movd = is_sys && (func == F_MOVD);
    assign is_ret  = is_sys && (func == F_RET);

    assign ip_inc     = ip + 1'b1;
    assign ip_inc2    = ip + 2'd2;
    assign sp_inc     = sp + 1'b1;
    assign sp_dec     = sp - 1'b1;
    assign jmp_target = taken ? ir.jmp_f.addr : ip_inc;

    // r5 for jumps, rd for read-modify-write immediates
    assign rd_idx0  = is_jump ? `CORE_REG_AW'(`CORE_COND_REG) :
                      (is_imm ? ir.reg_f.rd : ir.reg_f.ra);
    assign rd_idx1  = ir.reg_f.rb;
    assign alu_arg1 = (!is_jump && (op == OP_ARITH || op == OP_LOGIC)) ?
                      rd_data1 : `CORE_DATA_W'(ir.imm_f.imm);

    assign write_high = (is_sys && func == F_PUSHH) ||
                        (!is_jump && op == OP_STORE && ir.reg_f.sub == 2'd1);

    always_comb begin
        alu_op = ALU_PASS;
        if (!is_jump) begin
            case (op)
                OP_ARITH: begin
                    case (ir.reg_f.sub)
                        2'd0: alu_op = ALU_ADD;
                        2'd1: alu_op = ALU_SUB;
                        default: alu_op = ALU_MUL;
                    endcase
                end
                OP_LOGIC: begin
                    case (ir.reg_f.sub)
                        2'd0: alu_op = ALU_AND;
                        2'd1: alu_op = ALU_OR;
                        default: alu_op = ALU_XOR;
                    endcase
                end
                OP_ADDB: alu_op = ALU_ADD;
                OP_SUBB: alu_op = ALU_SUB;
                OP_MULB: alu_op = ALU_MUL;
                OP_SYS: begin
                    if (func == F_NOT) begin
                        alu_op = ALU_NOT;
                    end else if (func == F_NEG) begin
                        alu_op = ALU_NEG;
                    end
                end
                default: alu_op = ALU_PASS;
            endcase
        end
    end

    // Byte inserts patch the passed-through rd
    always_comb begin
        ex_data = alu_ans;
        case (op)
            OP_MOVLL: ex_data[7:0]   = ir.imm_f.imm;
            OP_MOVLH: ex_data[15:8]  = ir.imm_f.imm;
            OP_MOVHL: ex_data[23:16] = ir.imm_f.imm;
            OP_MOVHH: ex_data[31:24] = ir.imm_f.imm;
            default: ;
        endcase
    end

    always_comb begin
        exec_wr = 1'b0;
        if (!is_jump) begin
            case (op)
                OP_ARITH, OP_LOGIC: exec_wr = (ir.reg_f.sub != 2'd3);
                OP_SYS: exec_wr = func inside {F_MOV, F_NOT, F_NEG};
                default: exec_wr = is_imm;
            endcase
        end
    end

    always_comb begin
        case (cond)
            C_CALL, C_JMP: taken = 1'b1;
            C_JEZ: taken = ~|rd_data0;
            C_JNZ: taken = |rd_data0;
            C_JAZ: taken = !rd_data0[`CORE_DATA_W-1] && |rd_data0;
            C_JBZ: taken = rd_data0[`CORE_DATA_W-1];
            C_JAEZ: taken = !rd_data0[`CORE_DATA_W-1];
            C_JBEZ: taken = rd_data0[`CORE_DATA_W-1] || ~|rd_data0;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        wr_idx  = ir.reg_f.rd;
        wr_en_h = 1'b0;
        wr_en_l = 1'b0;
        wr_data = ex_data;
        case (state)
            S_EXEC: begin
                wr_en_h = exec_wr;
                wr_en_l = exec_wr;
            end
            S_MHIGH: begin  // First constant word of MOVD
                wr_idx  = pend_idx;
                wr_en_h = 1'b1;
                wr_data = {ram_q, ram_q};
            end
            S_MDATA: begin
                wr_idx  = pend_idx;
                wr_en_h = pend_h;
                wr_en_l = pend_l;
                wr_data = {ram_q, ram_q};
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (state == S_WAIT) begin
            ir <= ram_q;
        end
        if (state == S_EXEC) begin
            pend_idx <= ir.reg_f.rd;
            if (is_jump) begin
                ram_data <= `CORE_INSTR_W'(ip_inc);  // Return address for CALL
            end else if (write_high) begin
                ram_data <= rd_data0[`CORE_DATA_W-1:HALF];
            end else begin
                ram_data <= rd_data0[HALF-1:0];
            end
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_ISSUE;
            ip       <= `CORE_ADDR_W'(`CORE_RESET_IP);
            ram_addr <= `CORE_ADDR_W'(`CORE_RESET_IP);
            sp       <= '1;
            ram_wren <= 1'b0;
            out_data <= '0;
            running  <= 1'b1;
            pend_h   <= 1'b0;
            pend_l   <= 1'b0;
        end else begin
            case (state)
                S_ISSUE: state <= S_WAIT;
                S_WAIT: state <= S_EXEC;
                S_EXEC: begin
                    state    <= S_ISSUE;
                    ip       <= ip_inc;
                    ram_addr <= ip_inc;
                    pend_h   <= 1'b0;
                    pend_l   <= 1'b0;
                    if (is_jump) begin
                        if (cond == C_CALL) begin
                            sp       <= sp_dec;
                            ram_addr <= {{PAGE_W{1'b1}}, sp};
                            ram_wren <= 1'b1;
                            ip       <= ir.jmp_f.addr;
                            state    <= S_STORE;
                        end else begin
                            ip       <= jmp_target;
                            ram_addr <= jmp_target;
                        end
                    end else if (op == OP_STORE && !ir.reg_f.sub[1]) begin
                        ram_addr <= rd_data1[`CORE_ADDR_W-1:0];
                        ram_wren <= 1'b1;
                        state    <= S_STORE;
                    end else if (is_sys) begin
                        case (func)
                            F_END: begin
                                running <= 1'b0;
                                state   <= S_HALT;
                            end
                            F_RET: begin
                                sp       <= sp_inc;
                                ram_addr <= {{PAGE_W{1'b1}}, sp_inc};
                                state    <= S_MADDR;
                            end
                            F_NOP: ;
                            F_OUT: out_data <= alu_ans;
                            F_PUSHL, F_PUSHH: begin
                                sp       <= sp_dec;
                                ram_addr <= {{PAGE_W{1'b1}}, sp};
                                ram_wren <= 1'b1;
                                state    <= S_STORE;
                            end
                            F_LDRAML, F_LDRAMH: begin
                                ram_addr <= rd_data0[`CORE_ADDR_W-1:0];
                                pend_l   <= (func == F_LDRAML);
                                pend_h   <= (func == F_LDRAMH);
                                state    <= S_MADDR;
                            end
                            F_POPL, F_POPH: begin
                                sp       <= sp_inc;
                                ram_addr <= {{PAGE_W{1'b1}}, sp_inc};
                                pend_l   <= (func == F_POPL);
                                pend_h   <= (func == F_POPH);
                                state    <= S_MADDR;
                            end
                            F_MOVL, F_MOVH, F_MOVD: begin
                                ip       <= ip_inc2;  // Skip the constant
                                pend_l   <= (func != F_MOVH);
                                pend_h   <= (func == F_MOVH);
                                state    <= S_MADDR;
                            end
                            default: ;
                        endcase
                    end
                end
                S_MADDR: begin
                    if (is_movd) begin
                        ram_addr <= ip;
                        ip       <= ip_inc;
                        state    <= S_MHIGH;
                    end else begin
                        state    <= S_MDATA;
                    end
                end
                S_MHIGH: state <= S_MDATA;
                S_MDATA: begin
                    state <= S_ISSUE;
                    if (is_ret) begin
                        ip       <= ram_q[`CORE_ADDR_W-1:0];
                        ram_addr <= ram_q[`CORE_ADDR_W-1:0];
                    end else begin
                        ram_addr <= ip;
                    end
                end
                S_STORE: begin
                    ram_wren <= 1'b0;
                    ram_addr <= ip;
                    state    <= S_ISSUE;
                end
                S_HALT: state <= S_HALT;
                default: state <= S_ISSUE;
            endcase
        end
    end

endmodule

//--- logic/core_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_top (
    input  logic                     CLK,
    input  logic                     arst_n,
    input  logic [`CORE_INSTR_W-1:0] ram_q,
    output logic [`CORE_ADDR_W-1:0]  ram_addr,
    output logic                     ram_wren,
    output logic [`CORE_INSTR_W-1:0] ram_data,
    output logic [`CORE_DATA_W-1:0]  out_data,
    output logic                     running
);
    import core_pkg::*;

    logic [`CORE_REG_AW-1:0] rd_idx0;
    logic [`CORE_REG_AW-1:0] rd_idx1;
    logic [`CORE_REG_AW-1:0] wr_idx;
    logic                    wr_en_h;
    logic                    wr_en_l;
    logic [`CORE_DATA_W-1:0] wr_data;
    logic [`CORE_DATA_W-1:0] rd_data0;
    logic [`CORE_DATA_W-1:0] rd_data1;
    logic [`CORE_DATA_W-1:0] alu_arg1;
    logic [`CORE_DATA_W-1:0] alu_ans;
    alu_op_e                 alu_op;

    core_control u_control (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .ram_q    (ram_q),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1),
        .alu_ans  (alu_ans),
        .rd_idx0  (rd_idx0),
        .rd_idx1  (rd_idx1),
        .wr_idx   (wr_idx),
        .wr_en_h  (wr_en_h),
        .wr_en_l  (wr_en_l),
        .wr_data  (wr_data),
        .alu_op   (alu_op),
        .alu_arg1 (alu_arg1),
        .ram_addr (ram_addr),
        .ram_wren (ram_wren),
        .ram_data (ram_data),
        .out_data (out_data),
        .running  (running)
    );

    core_regfile u_regfile (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .rd_idx0  (rd_idx0),
        .rd_idx1  (rd_idx1),
        .wr_idx   (wr_idx),
        .wr_en_h  (wr_en_h),
        .wr_en_l  (wr_en_l),
        .wr_data  (wr_data),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1)
    );

    // First operand always comes from read port 0
    core_alu u_alu (
        .alu_op (alu_op),
        .arg0   (rd_data0),
        .arg1   (alu_arg1),
        .ans    (alu_ans)
    );

endmodule

//--- verif/core_sva.sv
`timescale 1ns/1ps

module core_sva (
    input logic CLK,
    input logic arst_n,
    input logic ram_wren,
    input logic running
);
    int fails = 0;  // Read by the testbench at the end of the run

    wren_single: assert property (@(posedge CLK) disable iff (!arst_n)
        ram_wren |=> !ram_wren)
        else begin
            fails++;
            $error("ram_wren held high for two cycles");
        end

    // Halt is sticky until the next reset
    halt_sticky: assert property (@(posedge CLK) disable iff (!arst_n)
        !running |=> !running)
        else begin
            fails++;
            $error("running rose again without a reset");
        end

    no_write_halted: assert property (@(posedge CLK) disable iff (!arst_n)
        !running |-> !ram_wren)
        else begin
            fails++;
            $error("ram_wren high while halted");
        end

endmodule

bind core_top core_sva u_sva (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .ram_wren (ram_wren),
    .running  (running)
);

//--- verif/core_tb.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_tb;
    localparam int DATA_BASE = 'h200;  // Where the programs store results
    localparam int WORDS     = 1 << `CORE_ADDR_W;

    logic                     CLK;
    logic                     arst_n;
    logic [`CORE_INSTR_W-1:0] ram_q;
    logic [`CORE_ADDR_W-1:0]  ram_addr;
    logic                     ram_wren;
    logic [`CORE_INSTR_W-1:0] ram_data;
    logic [`CORE_DATA_W-1:0]  out_data;
    logic                     running;

    logic [`CORE_INSTR_W-1:0] mem [WORDS];
    logic [`CORE_INSTR_W-1:0] snap [WORDS];
    logic [`CORE_DATA_W-1:0]  expect_q [$];
    int                       pc;
    int                       cycles = 0;
    int                       limit = 200;

    core_top uut (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .ram_q    (ram_q),
        .ram_addr (ram_addr),
        .ram_wren (ram_wren),
        .ram_data (ram_data),
        .out_data (out_data),
        .running  (running)
    );

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    // Single-port RAM with one cycle read latency
    always @(posedge CLK) begin
        if (ram_wren) begin
            mem[ram_addr] <= ram_data;
        end
        ram_q <= mem[ram_addr];
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: the core did not halt within %0d cycles", limit);
            $display("Simulation failed");
            $fatal(1, "Run aborted by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h got %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic [15:0] enc_reg(input int op, input int rd, input int ra,
                                            input int rb, input int sub);
        return {1'b0, 4'(op), 3'(rd), 3'(ra), 3'(rb), 2'(sub)};
    endfunction

    function automatic logic [15:0] enc_imm(input int op, input int rd, input logic [7:0] imm);
        return {1'b0, 4'(op), 3'(rd), imm};
    endfunction

    function automatic logic [15:0] enc_sys(input int func, input int rd, input int ra);
        return {1'b0, 4'd0, 3'(rd), 3'(ra), 5'(func)};
    endfunction

    function automatic logic [15:0] enc_jmp(input int cond, input int addr);
        return {1'b1, 3'(cond), 12'(addr)};
    endfunction

    // Expected outcome of a conditional jump on r5
    function automatic bit jump_taken(input int cond, input logic [31:0] v);
        case (cond)
            1: return 1'b1;
            2: return v == 0;
            3: return v != 0;
            4: return !v[31] && v != 0;
            5: return v[31];
            6: return !v[31];
            default: return v[31] || v == 0;
        endcase
    endfunction

    task automatic emit(input logic [15:0] word);
        mem[pc] = word;
        pc++;
    endtask

    task automatic load_const(input int rd, input logic [31:0] value);
        emit(enc_sys(31, rd, 0));  // MOVD
        emit(value[31:16]);
        emit(value[15:0]);
    endtask

    // r7 walks through the result area
    task automatic store_reg(input int r, input logic [31:0] value);
        emit(enc_reg(3, 0, r, 7, 0));  // STRAML
        emit(enc_imm(8, 7, 8'd1));
        emit(enc_reg(3, 0, r, 7, 1));  // STRAMH
        emit(enc_imm(8, 7, 8'd1));
        expect_q.push_back(value);
    endtask

    task automatic begin_program();
        for (int a = 0; a < WORDS; a++) begin
            mem[a] = 16'hd000 | 16'(a);
        end
        pc = `CORE_RESET_IP;
        expect_q.delete();
        emit(enc_sys(29, 7, 0));  // MOVL r7
        emit(16'(DATA_BASE));
    endtask

    task automatic apply_reset();
        @(posedge CLK);
        arst_n <= 1'b0;
        repeat (2) @(posedge CLK);
        arst_n <= 1'b1;
    endtask

    task automatic start_program();
        emit(16'h0000);  // END
        limit += 6 * (pc - `CORE_RESET_IP);
        apply_reset();
    endtask

    task automatic wait_halt();
        @(negedge CLK);
        while (running !== 1'b0) begin
            @(negedge CLK);
        end
    endtask

    task automatic run_program();
        start_program();
        wait_halt();
    endtask

    task automatic check_stores();
        logic [31:0] word;
        for (int i = 0; i < expect_q.size(); i++) begin
            word = {mem[DATA_BASE + 2 * i + 1], mem[DATA_BASE + 2 * i]};
            check_value($sformatf("ram word %h", DATA_BASE + 2 * i), expect_q[i], word);
        end
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] acc;
        logic [7:0]  imm0;
        logic [7:0]  imm1;
        logic [7:0]  imm2;
        a = $urandom();
        b = $urandom();
        imm0 = 8'($urandom());
        imm1 = 8'($urandom());
        imm2 = 8'($urandom());
        begin_program();
        load_const(1, a);
        load_const(2, b);
        emit(enc_reg(1, 3, 1, 2, 0));  // ADD
        store_reg(3, a + b);
        emit(enc_reg(1, 3, 1, 2, 1));  // SUB
        store_reg(3, a - b);
        emit(enc_reg(1, 3, 1, 2, 2));  // MUL
        store_reg(3, a * b);
        emit(enc_reg(2, 3, 1, 2, 0));  // AND
        store_reg(3, a & b);
        emit(enc_reg(2, 3, 1, 2, 1));  // OR
        store_reg(3, a | b);
        emit(enc_reg(2, 3, 1, 2, 2));  // XOR
        store_reg(3, a ^ b);
        emit(enc_sys(17, 3, 1));  // NOT
        store_reg(3, ~a);
        emit(enc_sys(18, 3, 1));  // NEG
        store_reg(3, -a);
        emit(enc_sys(16, 3, 2));  // MOV
        store_reg(3, b);
        emit(enc_sys(16, 4, 1));
        acc = a + 32'(imm0);
        emit(enc_imm(8, 4, imm0));  // ADDB
        store_reg(4, acc);
        acc = acc - 32'(imm1);
        emit(enc_imm(9, 4, imm1));  // SUBB
        store_reg(4, acc);
        acc = acc * 32'(imm2);
        emit(enc_imm(10, 4, imm2));  // MULB
        store_reg(4, acc);
        emit(enc_sys(12, 0, 4));  // OUT r4
        run_program();
        check_stores();
        check_value("out_data", acc, out_data);
    endtask

    task automatic test_reset_state();
        begin_program();
        start_program();
        @(negedge CLK);
        check_value("ram_wren", 1'b0, ram_wren);
        check_value("running", 1'b1, running);
        check_value("ram_addr", 32'h8, ram_addr);  // Reset entry word
        check_value("out_data", 0, out_data);
        wait_halt();
    endtask

    task automatic test_consts();
        logic [31:0] v;
        logic [31:0] w;
        v = $urandom();
        w = $urandom();
        begin_program();
        emit(enc_imm(4, 1, v[7:0]));  // MOVLL
        emit(enc_imm(5, 1, v[15:8]));
        emit(enc_imm(6, 1, v[23:16]));
        emit(enc_imm(7, 1, v[31:24]));
        store_reg(1, v);  // Lands at DATA_BASE
        load_const(2, w);
        emit(enc_imm(6, 2, v[7:0]));  // Other bytes must survive
        store_reg(2, {w[31:24], v[7:0], w[15:0]});
        emit(enc_sys(29, 3, 0));  // MOVL
        emit(w[15:0]);
        store_reg(3, {16'h0000, w[15:0]});
        emit(enc_sys(30, 3, 0));  // MOVH
        emit(v[31:16]);
        store_reg(3, {v[31:16], w[15:0]});
        emit(enc_sys(29, 6, 0));
        emit(16'(DATA_BASE));
        emit(enc_sys(24, 5, 6));  // LDRAML
        emit(enc_imm(8, 6, 8'd1));
        emit(enc_sys(25, 5, 6));  // LDRAMH
        store_reg(5, v);
        run_program();
        check_stores();
    endtask

    task automatic test_jumps(input logic [31:0] r5_val);
        int at;
        int skip_at;
        begin_program();
        load_const(5, r5_val);
        for (int c = 1; c < 8; c++) begin
            at = pc;
            emit(16'h0000);  // Patched once the target is known
            emit(enc_sys(29, 1, 0));
            emit(16'h3000 + 16'(c));  // Fall-through marker
            skip_at = pc;
            emit(16'h0000);
            mem[at] = enc_jmp(c, pc);
            emit(enc_sys(29, 1, 0));
            emit(16'h7000 + 16'(c));  // Taken marker
            mem[skip_at] = enc_jmp(1, pc);
            store_reg(1, jump_taken(c, r5_val) ? 32'h7000 + c : 32'h3000 + c);
        end
        run_program();
        check_stores();
    endtask

    task automatic test_stack();
        logic [31:0] v;
        int          call_at;
        v = $urandom();
        begin_program();
        call_at = pc;
        emit(16'h0000);
        store_reg(4, 32'h0000_5a3c);  // Runs only after RET
        load_const(1, v);
        emit(enc_sys(13, 0, 1));  // PUSHL
        emit(enc_sys(14, 0, 1));  // PUSHH
        emit(enc_sys(27, 2, 0));  // POPH
        emit(enc_sys(26, 2, 0));  // POPL
        store_reg(2, v);
        emit(16'h0000);
        mem[call_at] = enc_jmp(0, pc);  // CALL
        emit(enc_sys(29, 4, 0));
        emit(16'h5a3c);
        emit(enc_sys(1, 0, 0));  // RET
        run_program();
        check_stores();
        check_value("stack word fff", v[15:0], mem[12'hfff]);
        check_value("stack word ffe", v[31:16], mem[12'hffe]);
    endtask

    task automatic test_halt();
        logic [31:0] v;
        v = $urandom();
        begin_program();
        load_const(1, v);
        store_reg(1, v);
        run_program();
        check_stores();
        snap = mem;
        repeat (20) begin
            @(negedge CLK);
            check_value("running", 1'b0, running);
            check_value("ram_wren", 1'b0, ram_wren);
        end
        for (int a = 0; a < WORDS; a++) begin
            check_value($sformatf("ram word %h", a), snap[a], mem[a]);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        ram_q  = '0;
        void'($urandom(32'h27a1));
        test_alu();
        test_reset_state();
        test_consts();
        test_jumps($urandom() | 32'h8000_0000);
        test_jumps(32'h0000_0000);
        test_jumps(($urandom() & 32'h7fff_ffff) | 32'h1);
        test_stack();
        test_halt();
        if (uut.u_sva.fails == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "%0d assertion failures", uut.u_sva.fails);
        end
    end

endmodule

//--- filelist.f
+incdir+include
logic/core_pkg.sv
logic/core_regfile.sv
logic/core_alu.sv
logic/core_control.sv
logic/core_top.sv
verif/core_sva.sv
verif/core_tb.sv

//--- Bender.yml
package:
  name: core

export_include_dirs:
  - include

sources:
  - logic/core_pkg.sv
  - logic/core_regfile.sv
  - logic/core_alu.sv
  - logic/core_control.sv
  - logic/core_top.sv
  - target: test
    files:
      - verif/core_sva.sv
      - verif/core_tb.sv
